// File: design/ooo_pkg.sv
`default_nettype none

package ooo_pkg;
	localparam int ROB_WIDTH = 4; // tag is a reorder buffer index

	typedef struct packed {
		logic valid; // data present, otherwise waiting on tag
		logic [ROB_WIDTH-1:0] tag;
		logic [31:0] data;
	} opd_t;

	typedef struct packed {
		logic valid;
		logic [ROB_WIDTH-1:0] tag;
		logic [31:0] data;
	} cdb_t;

	typedef enum logic [1:0] {
		op_itof = 2'd0,
		op_add = 2'd1,
		op_sub = 2'd2
	} opcode_t;

	// capture a broadcast into a waiting operand
	function automatic opd_t wake(opd_t o, cdb_t c);
		opd_t r;
		r = o;
		if (!o.valid && c.valid && c.tag == o.tag) begin
			r.valid = 1'b1;
			r.data = c.data;
		end
		return r;
	endfunction
endpackage

`default_nettype wire

// File: design/issue_if.sv
`default_nettype none

interface issue_if;
	logic valid;
	logic ready;
	ooo_pkg::opcode_t op;
	logic [ooo_pkg::ROB_WIDTH-1:0] tag; // destination
	ooo_pkg::opd_t a;
	ooo_pkg::opd_t b;

	modport source (
		output valid, op, tag, a, b,
		input ready
	);

	modport sink (
		input valid, op, tag, a, b,
		output ready
	);
endinterface

`default_nettype wire

// File: design/cdb_req_if.sv
`default_nettype none

interface cdb_req_if;
	logic valid;
	logic ready; // grant from the arbiter
	logic [ooo_pkg::ROB_WIDTH-1:0] tag;
	logic [31:0] data;

	modport source (output valid, tag, data, input ready);
	modport arbiter (input valid, tag, data, output ready);
endinterface

`default_nettype wire

// File: design/itof_convert.sv
`default_nettype none

module itof_convert (
	input logic [31:0] value,
	output logic [31:0] result
);
	logic sign;
	logic [31:0] mag;
	logic [4:0] lead;
	logic [31:0] norm;
	logic [22:0] mant;
	logic guard;
	logic sticky;
	logic round_up;
	logic [23:0] rounded;
	logic [7:0] expo;

	assign sign = value[31];
	assign mag = sign ? -value : value; // -2^31 stays 0x80000000

	// position of the leading one
	always_comb begin
		lead = '0;
		for (int i = 0; i < 32; i++) begin
			if (mag[i]) begin
				lead = 5'(i);
			end
		end
	end

	assign norm = mag << (5'd31 - lead); // leading one at bit 31
	assign mant = norm[30:8];
	assign guard = norm[7];
	assign sticky = |norm[6:0];
	assign round_up = guard && (sticky || mant[0]); // nearest, ties to even

	// carry out of the mantissa bumps the exponent, fraction wraps to 0
	assign rounded = {1'b0, mant} + 24'(round_up);
	assign expo = 8'd127 + 8'(lead) + 8'(rounded[23]);

	always_comb begin
		if (mag == '0) begin
			result = 32'h0000_0000; // +0.0
		end else begin
			result = {sign, expo, rounded[22:0]};
		end
	end
endmodule

`default_nettype wire

// File: design/itof_station.sv
`default_nettype none

module itof_station #(
	parameter int N_ENTRY = 2
) (
	input logic clk,
	input logic reset,
	issue_if.sink issue,
	input ooo_pkg::cdb_t cdb,
	cdb_req_if.source req
);
	localparam int IW = $clog2(N_ENTRY);

	typedef struct packed {
		logic valid;
		logic [ooo_pkg::ROB_WIDTH-1:0] tag;
		ooo_pkg::opd_t a;
	} entry_t;

	entry_t e [N_ENTRY]; // packed from 0, oldest first
	entry_t e_upd [N_ENTRY+1]; // top slot is always empty
	entry_t e_shift [N_ENTRY];
	entry_t e_next [N_ENTRY];
	entry_t e_new;
	logic [N_ENTRY-1:0] rdy;
	logic [IW-1:0] d;
	logic dispatch;
	logic accept;
	logic [31:0] result;

	assign e_new.valid = 1'b1;
	assign e_new.tag = issue.tag;
	assign e_new.a = ooo_pkg::wake(issue.a, cdb); // same-cycle wakeup

	always_comb begin
		for (int i = 0; i < N_ENTRY; i++) begin
			e_upd[i] = e[i];
			e_upd[i].a = ooo_pkg::wake(e[i].a, cdb);
			rdy[i] = e[i].valid && e[i].a.valid;
		end
		e_upd[N_ENTRY] = '0;
	end

	// oldest ready entry
	always_comb begin
		d = '0;
		for (int i = N_ENTRY - 1; i >= 0; i--) begin
			if (rdy[i]) begin
				d = IW'(i);
			end
		end
	end

	assign req.valid = |rdy;
	assign req.tag = e[d].tag;
	assign req.data = result;
	assign dispatch = req.valid && req.ready;
	assign issue.ready = dispatch || !e[N_ENTRY-1].valid;
	assign accept = issue.valid && issue.ready;

	always_comb begin
		logic prev_valid;
		prev_valid = 1'b1;
		for (int i = 0; i < N_ENTRY; i++) begin
			e_shift[i] = (dispatch && i >= int'(d)) ? e_upd[i+1] : e_upd[i];
		end
		for (int i = 0; i < N_ENTRY; i++) begin
			e_next[i] = e_shift[i];
			if (accept && prev_valid && !e_shift[i].valid) begin
				e_next[i] = e_new; // first free slot
			end
			prev_valid = e_shift[i].valid;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < N_ENTRY; i++) begin
				e[i].valid <= 1'b0;
			end
		end else begin
			e <= e_next;
		end
	end

	itof_convert u_convert (
		.value(e[d].a.data),
		.result(result)
	);
endmodule

`default_nettype wire

// File: design/alu_station.sv
`default_nettype none

module alu_station #(
	parameter int N_ENTRY = 2
) (
	input logic clk,
	input logic reset,
	issue_if.sink issue,
	input ooo_pkg::cdb_t cdb,
	cdb_req_if.source req
);
	localparam int IW = $clog2(N_ENTRY);

	typedef struct packed {
		logic valid;
		ooo_pkg::opcode_t op;
		logic [ooo_pkg::ROB_WIDTH-1:0] tag;
		ooo_pkg::opd_t a;
		ooo_pkg::opd_t b;
	} entry_t;

	entry_t e [N_ENTRY];
	entry_t e_upd [N_ENTRY+1];
	entry_t e_shift [N_ENTRY];
	entry_t e_next [N_ENTRY];
	entry_t e_new;
	logic [N_ENTRY-1:0] rdy;
	logic [IW-1:0] d;
	logic dispatch;
	logic accept;

	assign e_new.valid = 1'b1;
	assign e_new.op = issue.op;
	assign e_new.tag = issue.tag;
	assign e_new.a = ooo_pkg::wake(issue.a, cdb);
	assign e_new.b = ooo_pkg::wake(issue.b, cdb);

	always_comb begin
		for (int i = 0; i < N_ENTRY; i++) begin
			e_upd[i] = e[i];
			e_upd[i].a = ooo_pkg::wake(e[i].a, cdb);
			e_upd[i].b = ooo_pkg::wake(e[i].b, cdb);
			rdy[i] = e[i].valid && e[i].a.valid && e[i].b.valid; // both operands in
		end
		e_upd[N_ENTRY] = '0;
	end

	always_comb begin
		d = '0;
		for (int i = N_ENTRY - 1; i >= 0; i--) begin
			if (rdy[i]) begin
				d = IW'(i);
			end
		end
	end

	assign req.valid = |rdy;
	assign req.tag = e[d].tag;
	assign req.data = (e[d].op == ooo_pkg::op_sub) ? e[d].a.data - e[d].b.data
		: e[d].a.data + e[d].b.data; // wraps
	assign dispatch = req.valid && req.ready;
	assign issue.ready = dispatch || !e[N_ENTRY-1].valid;
	assign accept = issue.valid && issue.ready;

	// close the gap left by the dispatched entry, then append
	always_comb begin
		logic prev_valid;
		prev_valid = 1'b1;
		for (int i = 0; i < N_ENTRY; i++) begin
			e_shift[i] = (dispatch && i >= int'(d)) ? e_upd[i+1] : e_upd[i];
		end
		for (int i = 0; i < N_ENTRY; i++) begin
			e_next[i] = e_shift[i];
			if (accept && prev_valid && !e_shift[i].valid) begin
				e_next[i] = e_new;
			end
			prev_valid = e_shift[i].valid;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < N_ENTRY; i++) begin
				e[i].valid <= 1'b0;
			end
		end else begin
			e <= e_next;
		end
	end
endmodule

`default_nettype wire

// File: design/cdb_arbiter.sv
`default_nettype none

module cdb_arbiter (
	input logic clk,
	input logic reset,
	cdb_req_if.arbiter itof_req,
	cdb_req_if.arbiter alu_req,
	input logic cdb_ready,
	output ooo_pkg::cdb_t cdb
);
	logic out_valid;
	logic [ooo_pkg::ROB_WIDTH-1:0] out_tag;
	logic [31:0] out_data;
	logic prio; // 0 favors itof, 1 favors alu
	logic can_accept;
	logic grant_itof;
	logic grant_alu;

	assign can_accept = !out_valid || cdb_ready; // empty or draining now

	assign grant_itof = can_accept && itof_req.valid && (!alu_req.valid || !prio);
	assign grant_alu = can_accept && alu_req.valid && (!itof_req.valid || prio);
	assign itof_req.ready = grant_itof;
	assign alu_req.ready = grant_alu;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			prio <= 1'b0;
		end else if (grant_itof || grant_alu) begin
			out_valid <= 1'b1;
			prio <= ~prio;
		end else if (cdb_ready) begin
			out_valid <= 1'b0;
		end
	end

	// payload holds while stalled
	always_ff @(posedge clk) begin
		if (grant_itof) begin
			out_tag <= itof_req.tag;
			out_data <= itof_req.data;
		end else if (grant_alu) begin
			out_tag <= alu_req.tag;
			out_data <= alu_req.data;
		end
	end

	assign cdb.valid = out_valid;
	assign cdb.tag = out_tag;
	assign cdb.data = out_data;
endmodule

`default_nettype wire

// File: design/exec_cluster.sv
`default_nettype none

module exec_cluster #(
	parameter int N_ENTRY = 2
) (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input ooo_pkg::opcode_t issue_op,
	input logic [ooo_pkg::ROB_WIDTH-1:0] issue_tag,
	input ooo_pkg::opd_t issue_a,
	input ooo_pkg::opd_t issue_b,
	output logic issue_ready,
	input logic cdb_ready,
	output logic cdb_valid,
	output logic [ooo_pkg::ROB_WIDTH-1:0] cdb_tag,
	output logic [31:0] cdb_data
);
	issue_if itof_issue ();
	issue_if alu_issue ();
	cdb_req_if itof_req ();
	cdb_req_if alu_req ();
	ooo_pkg::cdb_t cdb;
	ooo_pkg::cdb_t cdb_snoop;
	logic is_itof;

	assign is_itof = (issue_op == ooo_pkg::op_itof);

	assign itof_issue.valid = issue_valid && is_itof;
	assign itof_issue.op = issue_op;
	assign itof_issue.tag = issue_tag;
	assign itof_issue.a = issue_a;
	assign itof_issue.b = issue_b;

	assign alu_issue.valid = issue_valid && !is_itof;
	assign alu_issue.op = issue_op;
	assign alu_issue.tag = issue_tag;
	assign alu_issue.a = issue_a;
	assign alu_issue.b = issue_b;

	assign issue_ready = is_itof ? itof_issue.ready : alu_issue.ready;

	// stations only see broadcasts the reorder buffer takes
	assign cdb_snoop.valid = cdb.valid && cdb_ready;
	assign cdb_snoop.tag = cdb.tag;
	assign cdb_snoop.data = cdb.data;

	itof_station #(.N_ENTRY(N_ENTRY)) u_itof (
		.clk(clk), .reset(reset), .issue(itof_issue), .cdb(cdb_snoop), .req(itof_req)
	);

	alu_station #(.N_ENTRY(N_ENTRY)) u_alu (
		.clk(clk), .reset(reset), .issue(alu_issue), .cdb(cdb_snoop), .req(alu_req)
	);

	cdb_arbiter u_arb (
		.clk(clk), .reset(reset), .itof_req(itof_req), .alu_req(alu_req),
		.cdb_ready(cdb_ready), .cdb(cdb)
	);

	assign cdb_valid = cdb.valid;
	assign cdb_tag = cdb.tag;
	assign cdb_data = cdb.data;
endmodule

`default_nettype wire

// File: dv/exec_cluster_tb.sv
`default_nettype none

module exec_cluster_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_ENTRY = 2;
	localparam int COLS = 10; // words per trace line
	localparam int MAX_LINES = 32;

	logic clk;
	logic reset;
	logic issue_valid;
	ooo_pkg::opcode_t issue_op;
	logic [ooo_pkg::ROB_WIDTH-1:0] issue_tag;
	ooo_pkg::opd_t issue_a;
	ooo_pkg::opd_t issue_b;
	logic issue_ready;
	logic cdb_ready;
	logic cdb_valid;
	logic [ooo_pkg::ROB_WIDTH-1:0] cdb_tag;
	logic [31:0] cdb_data;

	logic [31:0] trace [COLS*MAX_LINES];
	int n_lines;
	int limit;
	int cycles;
	int errors;
	int checks;
	logic random_ready;
	integer seed;

	// scoreboard of the test in progress
	logic issued [16];
	int seen [16];
	logic [31:0] expected [16];
	int n_issued;
	int n_seen;
	int stalls;

	logic held; // broadcast stalled at the last sample
	logic [ooo_pkg::ROB_WIDTH-1:0] held_tag;
	logic [31:0] held_data;

	exec_cluster #(.N_ENTRY(N_ENTRY)) dut0 (
		.clk(clk), .reset(reset), .issue_valid(issue_valid), .issue_op(issue_op),
		.issue_tag(issue_tag), .issue_a(issue_a), .issue_b(issue_b),
		.issue_ready(issue_ready), .cdb_ready(cdb_ready), .cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag), .cdb_data(cdb_data)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		int r;
		#1;
		r = $random(seed);
		cdb_ready = random_ready ? r[0] : 1'b1;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout after %0d cycles, %0d of %0d results broadcast in this test",
				cycles, n_seen, n_issued);
			$display("TEST FAILED");
			$finish;
		end
	end

	always @(negedge clk) begin
		if (!reset) begin
			if (held) begin
				checks++;
				assert (cdb_valid && cdb_tag == held_tag && cdb_data == held_data) else begin
					errors++;
					$display("CHECK FAILED at %0t: stalled broadcast of tag %0d changed",
						$time, held_tag);
				end
			end
			if (cdb_valid && cdb_ready) begin
				checks++;
				assert (issued[cdb_tag]) else begin
					errors++;
					$display("at %0t: tag %0d broadcast but not in flight", $time, cdb_tag);
				end
				assert (seen[cdb_tag] == 0) else begin
					errors++;
					$display("at %0t: tag %0d broadcast more than once", $time, cdb_tag);
				end
				assert (cdb_data == expected[cdb_tag]) else begin
					errors++;
					$display("CHECK FAILED at %0t: tag %0d broadcast %h, expected %h",
						$time, cdb_tag, cdb_data, expected[cdb_tag]);
				end
				if (issued[cdb_tag] && seen[cdb_tag] == 0) begin
					n_seen++;
				end
				seen[cdb_tag]++;
			end
			held = cdb_valid && !cdb_ready;
			held_tag = cdb_tag;
			held_data = cdb_data;
		end
	end

	// present one trace line and hold it until the station takes it
	task automatic issue_line(input int base);
		logic taken;
		@(posedge clk);
		#1;
		issue_valid = 1'b1;
		issue_op = ooo_pkg::opcode_t'(trace[base+1][1:0]);
		issue_tag = trace[base+2][3:0];
		issue_a.valid = trace[base+3][0];
		issue_a.tag = trace[base+4][3:0];
		issue_a.data = trace[base+5];
		issue_b.valid = trace[base+6][0];
		issue_b.tag = trace[base+7][3:0];
		issue_b.data = trace[base+8];
		issued[issue_tag] = 1'b1;
		expected[issue_tag] = trace[base+9];
		n_issued++;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = issue_ready;
			if (!taken) begin
				stalls++;
			end
		end
	endtask

	task automatic clear_scoreboard();
		for (int i = 0; i < 16; i++) begin
			issued[i] = 1'b0;
			seen[i] = 0;
			expected[i] = '0;
		end
		n_issued = 0;
		n_seen = 0;
		stalls = 0;
	endtask

	initial begin
		int t;
		int first;
		int k;
		int err0;
		int n_tests;
		clk = 1'b0;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_op = ooo_pkg::op_itof;
		issue_tag = '0;
		issue_a = '0;
		issue_b = '0;
		cdb_ready = 1'b1;
		random_ready = 1'b0;
		seed = 32'hb223_b09d;
		errors = 0;
		checks = 0;
		cycles = 0;
		held = 1'b0;
		n_tests = 0;
		clear_scoreboard();
		for (int i = 0; i < COLS * MAX_LINES; i++) begin
			trace[i] = 32'hffff_0000 | 32'(i); // out of range as a test number
		end
		$readmemh("dv/exec_trace.txt", trace);
		n_lines = 0;
		while (n_lines < MAX_LINES && trace[COLS*n_lines] inside {[1:15]}) begin
			n_lines++;
		end
		limit = 20 * n_lines + 100;

		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
		@(negedge clk);
		checks++;
		assert (!cdb_valid && issue_ready) else begin
			errors++;
			$display("CHECK FAILED at %0t: cluster not idle after reset", $time);
		end

		first = 0;
		while (first < n_lines) begin
			t = trace[COLS*first];
			err0 = errors;
			clear_scoreboard();
			random_ready = (t > 3); // first three tests keep the bus ready
			k = first;
			while (k < n_lines && trace[COLS*k] == t) begin
				issue_line(COLS * k);
				k++;
			end
			@(posedge clk);
			#1 issue_valid = 1'b0;
			while (n_seen < n_issued) begin
				@(posedge clk);
			end
			if (t == 5) begin
				checks++; // test 5 overfills the itof station
				assert (stalls > 0) else begin
					errors++;
					$display("issue_ready never dropped while the itof station was full");
				end
			end
			$display("test %0d: %0d instructions, %0d errors", t, n_issued, errors - err0);
			n_tests++;
			first = k;
		end

		repeat (10) @(posedge clk); // catch stray broadcasts
		$display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end
endmodule

`default_nettype wire

// File: list.f
design/ooo_pkg.sv
design/issue_if.sv
design/cdb_req_if.sv
design/itof_convert.sv
design/itof_station.sv
design/alu_station.sv
design/cdb_arbiter.sv
design/exec_cluster.sv
dv/exec_cluster_tb.sv

// File: Makefile
TOP = exec_cluster_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f list.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/exec_trace.txt
// test op tag a_valid a_tag a_data b_valid b_tag b_data expected
// op 0 itof, 1 add, 2 sub; all columns hex
1 0 0 1 0 00000000 1 0 00000000 00000000
1 0 1 1 0 00000001 1 0 00000000 3f800000
1 0 2 1 0 ffffffff 1 0 00000000 bf800000
1 0 3 1 0 7fffffff 1 0 00000000 4f000000
1 0 4 1 0 80000000 1 0 00000000 cf000000
1 0 5 1 0 01000001 1 0 00000000 4b800000
2 1 0 1 0 7fffffff 1 0 00000001 80000000
2 2 1 1 0 00000000 1 0 00000001 ffffffff
2 1 2 1 0 ffffffff 1 0 ffffffff fffffffe
3 0 0 1 0 00000005 1 0 00000000 40a00000
3 1 1 1 0 0000000a 1 0 00000014 0000001e
3 1 2 0 0 00000000 1 0 00000001 40a00001
3 2 3 0 2 00000000 0 1 00000000 409fffe3
4 0 0 1 0 00000003 1 0 00000000 40400000
4 1 1 1 0 00001000 1 0 00000234 00001234
4 0 2 1 0 fffffff6 1 0 00000000 c1200000
4 2 3 1 0 00000005 1 0 00000009 fffffffc
5 1 0 1 0 00000002 1 0 00000003 00000005
5 1 1 0 0 00000000 1 0 00000004 00000009
5 0 2 0 1 00000000 1 0 00000000 41100000
5 0 3 0 1 00000000 1 0 00000000 41100000
5 0 4 1 0 00000064 1 0 00000000 42c80000
